// File: include/mpf_defs.svh
// Shared sizes for the host shim
// Widths, read order buffer depth and write limit

`ifndef MPF_DEFS_SVH
`define MPF_DEFS_SVH

// ----------------------------------------
// Line format
// ----------------------------------------
`define MPF_ADDR_W      32      // Line address
`define MPF_DATA_W      64      // Line payload, cut down for simulation
`define MPF_TAG_W       8       // Metadata tag carried with each request

// ----------------------------------------
// Read order buffer
// ----------------------------------------
`define MPF_ROB_DEPTH   8       // Slots, one per read in flight
`define MPF_ROB_IDX_W   3       // log2 of depth

// ----------------------------------------
// Write channel
// ----------------------------------------
`define MPF_WR_MAX      4       // Writes allowed in flight

`endif

// File: sim.f
+incdir+include
verilog/mpfPkg.sv
verilog/hostChanIf.sv
verilog/hostWiresToIf.sv
verilog/readOrderBuffer.sv
verilog/afuRequestPort.sv
verilog/mpfShim.sv
tests/mpfShim_properties.sv
tests/mpfShim_tb.sv

// File: tests/mpfShim_properties.sv
// Read order buffer checks
// Bound assertions on slot order, tag use and read back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "mpf_defs.svh"

module mpfShim_properties
(
    input logic                         clk,
    input logic                         arstN,
    input logic                         rdValid,
    input logic                         rspValid,
    input logic [`MPF_ROB_DEPTH-1:0]    filled,
    input logic [`MPF_ROB_IDX_W-1:0]    oldestPtr,
    input logic                         rspWrite,
    input logic [`MPF_ROB_IDX_W-1:0]    rspSlot,
    input logic [`MPF_ROB_IDX_W:0]      freeCount
);

    localparam logic [`MPF_ROB_IDX_W:0] robDepth = (`MPF_ROB_IDX_W+1)'(`MPF_ROB_DEPTH);

    int failCount = 0;     // Running total of assertion failures

    logic [`MPF_ROB_IDX_W-1:0] slotOffset;     // Distance from oldest slot
    logic [`MPF_ROB_IDX_W:0]   inFlight;       // Slots handed out

    assign slotOffset = rspSlot - oldestPtr;
    assign inFlight   = robDepth - freeCount;

    // Released data must come from a slot handed out to a read
    releaseAllocated: assert property (@(posedge clk) disable iff (!arstN)
        rspValid |-> (inFlight != '0))
    else
    begin
        failCount++;
        $error("read data released from free slot %0d", oldestPtr);
    end

    // Response tag must name a slot in flight that has no data yet
    rspToAllocated: assert property (@(posedge clk) disable iff (!arstN)
        rspWrite |-> (({1'b0, slotOffset} < inFlight) && !filled[rspSlot]))
    else
    begin
        failCount++;
        $error("read response for free or filled slot %0d", rspSlot);
    end

    // No read while every slot is taken
    noReadWhenFull: assert property (@(posedge clk) disable iff (!arstN)
        !(rdValid && (freeCount == '0)))
    else
    begin
        failCount++;
        $error("read issued with no free slot, request dropped");
    end

endmodule

bind readOrderBuffer mpfShim_properties robProps
(
    .clk       (clk),
    .arstN     (arstN),
    .rdValid   (rdValid),
    .rspValid  (rspValid),
    .filled    (filled),
    .oldestPtr (oldestPtr),
    .rspWrite  (rspWrite),
    .rspSlot   (rspSlot),
    .freeCount (freeCount)
);

`default_nettype wire

// File: tests/mpfShim_tb.sv
// Host shim testbench
// Directed tests against a host model that answers reads out of order

`timescale 1ns/1ps
`default_nettype none

`include "mpf_defs.svh"

module mpfShim_tb
    import mpfPkg::*;
();

    localparam int timeoutCycles = 2000;   // Run needs a few hundred cycles
    localparam int waitLimit     = 100;    // Per wait on the DUT
    localparam logic [`MPF_DATA_W-1:0] dataMask = 64'hA5C3_0F96_5A3C_F069;

    logic                   clk;
    logic                   arstN;
    t_c0Req                 hostC0Tx;
    t_c1Req                 hostC1Tx;
    t_c0Rsp                 hostC0Rx;
    t_c1Rsp                 hostC1Rx;
    logic                   hostC0AlmFull;
    logic                   hostC1AlmFull;
    logic                   afuRdValid;
    logic [`MPF_ADDR_W-1:0] afuRdAddr;
    logic                   afuWrValid;
    logic [`MPF_ADDR_W-1:0] afuWrAddr;
    logic [`MPF_DATA_W-1:0] afuWrData;
    logic                   afuRdRspValid;
    logic [`MPF_DATA_W-1:0] afuRdRspData;
    logic                   afuWrAckValid;
    logic                   afuRdAlmFull;
    logic                   afuWrAlmFull;

    integer seed        = 32'h4e03_d675;
    int     cycleCount  = 0;
    int     errorCount  = 0;
    int     checkCount  = 0;
    int     ackCount    = 0;
    int     lastRspCycle;
    int     assertFails;
    bit     ackEnable   = 1'b0;     // Host holds write acks while low

    logic [`MPF_TAG_W-1:0]  rdTagQ[$];      // Reads seen on host c0, not yet answered
    logic [`MPF_ADDR_W-1:0] rdAddrQ[$];
    t_reqType               rdTypeQ[$];     // Opcode of each read seen on host c0
    logic [`MPF_ADDR_W-1:0] expAddrQ[$];    // Issue order from the accelerator
    logic [`MPF_DATA_W-1:0] rspDataQ[$];    // Data returned to the accelerator
    int                     rspCycleQ[$];
    logic [`MPF_TAG_W-1:0]  ackTagQ[$];     // Writes waiting for an ack
    int                     ackDueQ[$];
    logic [`MPF_ADDR_W-1:0] wrAddrQ[$];     // Writes seen on host c1
    logic [`MPF_DATA_W-1:0] wrDataQ[$];
    t_reqType               wrTypeQ[$];

    mpfShim mpfShim_inst
    (
        .clk           (clk),
        .arstN         (arstN),
        .hostC0Tx      (hostC0Tx),
        .hostC1Tx      (hostC1Tx),
        .hostC0Rx      (hostC0Rx),
        .hostC1Rx      (hostC1Rx),
        .hostC0AlmFull (hostC0AlmFull),
        .hostC1AlmFull (hostC1AlmFull),
        .afuRdValid    (afuRdValid),
        .afuRdAddr     (afuRdAddr),
        .afuWrValid    (afuWrValid),
        .afuWrAddr     (afuWrAddr),
        .afuWrData     (afuWrData),
        .afuRdRspValid (afuRdRspValid),
        .afuRdRspData  (afuRdRspData),
        .afuWrAckValid (afuWrAckValid),
        .afuRdAlmFull  (afuRdAlmFull),
        .afuWrAlmFull  (afuWrAlmFull)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;     // 4 ns period
    end

    // Cycle count and run limit
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles)
        begin
            $display("Timeout: tests still running after %0d cycles", cycleCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Host model and monitors
    // ----------------------------------------

    // Mid-cycle sampling, outputs settled
    always @(negedge clk)
    begin
        if (arstN && hostC0Tx.valid)
        begin
            rdTagQ.push_back(hostC0Tx.tag);
            rdAddrQ.push_back(hostC0Tx.addr);
            rdTypeQ.push_back(hostC0Tx.reqType);
        end
        if (arstN && hostC1Tx.valid)
        begin
            wrAddrQ.push_back(hostC1Tx.addr);
            wrDataQ.push_back(hostC1Tx.data);
            wrTypeQ.push_back(hostC1Tx.reqType);
            ackTagQ.push_back(hostC1Tx.tag);
            ackDueQ.push_back(cycleCount + 1 + ({$random(seed)} % 6));   // 1 to 6 cycles
        end
        if (afuRdRspValid)
        begin
            rspDataQ.push_back(afuRdRspData);
            rspCycleQ.push_back(cycleCount);
        end
        if (afuWrAckValid)
        begin
            ackCount++;
        end
    end

    // Write acks, in issue order, at most one per cycle
    initial
    begin
        hostC1Rx = '0;
        forever
        begin
            @(posedge clk);
            #1;
            hostC1Rx = '0;
            if (ackEnable && (ackTagQ.size() > 0) && (ackDueQ[0] <= cycleCount))
            begin
                hostC1Rx.valid   = 1'b1;
                hostC1Rx.rspType = eRspWrAck;
                hostC1Rx.tag     = ackTagQ.pop_front();
                void'(ackDueQ.pop_front());
            end
        end
    end

    // Predicted line content for an address
    function automatic logic [`MPF_DATA_W-1:0] lineData(input logic [`MPF_ADDR_W-1:0] addr);
        return {addr, addr} ^ dataMask;
    endfunction

    task automatic checkEq(input string testName, input logic [63:0] expected,
                           input logic [63:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    // Next drive point, just after the rising edge
    task automatic nextDrive();
        @(posedge clk);
        #1;
    endtask

    task automatic clearQueues();
        expAddrQ.delete();
        rspDataQ.delete();
        rspCycleQ.delete();
        rdTypeQ.delete();
    endtask

    // Back-to-back reads from consecutive addresses
    task automatic issueReads(input int count, input logic [`MPF_ADDR_W-1:0] base);
        int i;
        for (i = 0; i < count; i++)
        begin
            afuRdValid = 1'b1;
            afuRdAddr  = base + 32'(i);
            expAddrQ.push_back(base + 32'(i));
            nextDrive();
        end
        afuRdValid = 1'b0;
    endtask

    // Answer all pending reads in shuffled order, one per cycle
    task automatic answerReads();
        int                     i;
        int                     j;
        logic [`MPF_TAG_W-1:0]  tmpTag;
        logic [`MPF_ADDR_W-1:0] tmpAddr;
        for (i = rdTagQ.size() - 1; i > 0; i--)
        begin
            j          = {$random(seed)} % (i + 1);
            tmpTag     = rdTagQ[i];
            tmpAddr    = rdAddrQ[i];
            rdTagQ[i]  = rdTagQ[j];
            rdAddrQ[i] = rdAddrQ[j];
            rdTagQ[j]  = tmpTag;
            rdAddrQ[j] = tmpAddr;
        end
        while (rdTagQ.size() > 0)
        begin
            hostC0Rx.valid   = 1'b1;
            hostC0Rx.rspType = eRspRdLine;
            hostC0Rx.tag     = rdTagQ.pop_front();
            hostC0Rx.data    = lineData(rdAddrQ.pop_front());
            lastRspCycle     = cycleCount;
            nextDrive();
        end
        hostC0Rx = '0;
    endtask

    task automatic waitResponses(input string testName, input int count);
        int waited;
        waited = 0;
        while ((rspDataQ.size() < count) && (waited < waitLimit))
        begin
            nextDrive();
            waited++;
        end
        if (rspDataQ.size() < count)
        begin
            errorCount++;
            $display("%s: only %0d of %0d read responses came back",
                     testName, rspDataQ.size(), count);
        end
    endtask

    // Returned data against issue order
    task automatic checkReadOrder(input string testName);
        int i;
        checkEq(testName, expAddrQ.size(), rdTypeQ.size());    // Every read reached the host
        for (i = 0; i < rdTypeQ.size(); i++)
        begin
            checkEq(testName, eReqRdLine, rdTypeQ[i]);
        end
        checkEq(testName, expAddrQ.size(), rspDataQ.size());
        for (i = 0; (i < expAddrQ.size()) && (i < rspDataQ.size()); i++)
        begin
            checkEq(testName, lineData(expAddrQ[i]), rspDataQ[i]);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic resetState();
        @(negedge clk);
        checkEq("resetState", 0, hostC0Tx.valid);
        checkEq("resetState", 0, hostC1Tx.valid);
        checkEq("resetState", 0, afuRdRspValid);
        checkEq("resetState", 0, afuWrAckValid);
        checkEq("resetState", 0, afuRdAlmFull);
        checkEq("resetState", 0, afuWrAlmFull);
        nextDrive();
    endtask

    task automatic singleRead();
        clearQueues();
        issueReads(1, 32'h0000_1040);
        answerReads();
        waitResponses("singleRead", 1);
        if (rspCycleQ.size() > 0)
        begin
            checkEq("singleRead", 1, (rspCycleQ[0] - lastRspCycle) >= 2);  // Min latency
        end
        checkReadOrder("singleRead");
    endtask

    task automatic orderedReads();
        clearQueues();
        issueReads(`MPF_ROB_DEPTH, 32'h0002_0000);
        answerReads();
        waitResponses("orderedReads", `MPF_ROB_DEPTH);
        checkReadOrder("orderedReads");
    endtask

    task automatic readBackPressure();
        clearQueues();
        issueReads(`MPF_ROB_DEPTH - 1, 32'h0003_0100);   // One slot left
        @(negedge clk);
        checkEq("readBackPressure", 1, afuRdAlmFull);
        nextDrive();
        answerReads();
        waitResponses("readBackPressure", `MPF_ROB_DEPTH - 1);
        checkReadOrder("readBackPressure");
        @(negedge clk);
        checkEq("readBackPressure", 0, afuRdAlmFull);
        nextDrive();
        hostC0AlmFull = 1'b1;      // Host level alone
        @(negedge clk);
        checkEq("readBackPressure", 1, afuRdAlmFull);
        nextDrive();
        hostC0AlmFull = 1'b0;
        @(negedge clk);
        checkEq("readBackPressure", 0, afuRdAlmFull);
        nextDrive();
    endtask

    task automatic writeAcks();
        int                     i;
        int                     waited;
        logic [`MPF_ADDR_W-1:0] expAddr[3];
        logic [`MPF_DATA_W-1:0] expData[3];
        ackEnable = 1'b0;
        ackCount  = 0;
        wrAddrQ.delete();
        wrDataQ.delete();
        wrTypeQ.delete();
        for (i = 0; i < 3; i++)
        begin
            expAddr[i] = 32'h0004_0000 + 32'(i * 64);
            expData[i] = {32'hDA7A_0000 + 32'(i), ~expAddr[i]};
            afuWrValid = 1'b1;
            afuWrAddr  = expAddr[i];
            afuWrData  = expData[i];
            nextDrive();
            afuWrValid = 1'b0;
            @(negedge clk);
            checkEq("writeAcks", i == 2, afuWrAlmFull);   // High from the third write on
            nextDrive();
        end
        checkEq("writeAcks", 3, wrAddrQ.size());
        for (i = 0; (i < 3) && (i < wrAddrQ.size()); i++)
        begin
            checkEq("writeAcks", expAddr[i], wrAddrQ[i]);
            checkEq("writeAcks", expData[i], wrDataQ[i]);
            checkEq("writeAcks", eReqWrLine, wrTypeQ[i]);
        end
        ackEnable = 1'b1;          // Release the held acks
        waited    = 0;
        while ((ackCount < 3) && (waited < waitLimit))
        begin
            nextDrive();
            waited++;
        end
        repeat (8) nextDrive();    // Room for stray acks
        checkEq("writeAcks", 3, ackCount);
        @(negedge clk);
        checkEq("writeAcks", 0, afuWrAlmFull);
        nextDrive();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        arstN         = 1'b0;
        hostC0Rx      = '0;
        hostC0AlmFull = 1'b0;
        hostC1AlmFull = 1'b0;
        afuRdValid    = 1'b0;
        afuRdAddr     = '0;
        afuWrValid    = 1'b0;
        afuWrAddr     = '0;
        afuWrData     = '0;
        repeat (10) @(posedge clk);
        #1;
        arstN = 1'b1;

        resetState();
        singleRead();
        orderedReads();
        readBackPressure();
        writeAcks();

        assertFails = mpfShim_inst.readOrderBuffer_inst.robProps.failCount;
        if (assertFails != 0)
        begin
            errorCount += assertFails;
            $display("%0d assertion failures in the read order buffer", assertFails);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/afuRequestPort.sv
// Accelerator write port
// Issues writes on c1 with a rolling tag, limits writes in flight, passes acks back

`timescale 1ns/1ps
`default_nettype none

`include "mpf_defs.svh"

module afuRequestPort
    import mpfPkg::*;
(
    input  logic                    clk,
    input  logic                    arstN,

    // Accelerator side
    input  logic                    wrValid,
    input  logic [`MPF_ADDR_W-1:0]  wrAddr,
    input  logic [`MPF_DATA_W-1:0]  wrData,
    output logic                    wrAckValid,
    output logic                    wrAlmFull,

    // Host side
    hostChanIf.wr                   host
);

    localparam int cntW = $clog2(`MPF_WR_MAX + 1);

    localparam logic [cntW-1:0] wrMax    = cntW'(`MPF_WR_MAX);
    localparam logic [cntW-1:0] wrThresh = cntW'(`MPF_WR_MAX - 1);

    logic [cntW-1:0]       wrCount;    // Writes in flight
    logic [`MPF_TAG_W-1:0] wrTag;      // Rolling tag
    logic                  wrIssue;
    logic                  ackIn;

    assign wrIssue = wrValid && (wrCount != wrMax);    // Hard stop at the limit
    assign ackIn   = host.c1Rx.valid && (host.c1Rx.rspType == eRspWrAck);

    // ----------------------------------------
    // Request toward host
    // ----------------------------------------
    always_comb
    begin
        host.c1Tx.valid   = wrIssue;
        host.c1Tx.reqType = eReqWrLine;
        host.c1Tx.addr    = wrAddr;
        host.c1Tx.tag     = wrTag;
        host.c1Tx.data    = wrData;
    end

    // Outstanding count and tag
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            wrCount <= '0;
            wrTag   <= '0;
        end
        else
        begin
            if (wrIssue)
            begin
                wrTag <= wrTag + 1'b1;
            end
            case ({wrIssue, ackIn})
                2'b10:   wrCount <= wrCount + 1'b1;
                2'b01:   wrCount <= wrCount - 1'b1;
                default: wrCount <= wrCount;       // Issue and ack cancel
            endcase
        end
    end

    // ----------------------------------------
    // Accelerator outputs
    // ----------------------------------------
    assign wrAckValid = ackIn;     // One strobe per host ack
    assign wrAlmFull  = host.c1TxAlmFull || (wrCount >= wrThresh);

endmodule

`default_nettype wire

// File: verilog/hostChanIf.sv
// Host channel bundle
// Carries both request channels, both response channels and back-pressure

`timescale 1ns/1ps
`default_nettype none

interface hostChanIf
    import mpfPkg::*;
();

    t_c0Req c0Tx;           // Reads toward host
    t_c1Req c1Tx;           // Writes toward host
    t_c0Rsp c0Rx;           // Read data from host
    t_c1Rsp c1Rx;           // Write acks from host
    logic   c0TxAlmFull;    // Host c0 nearly full
    logic   c1TxAlmFull;    // Host c1 nearly full
    logic   rstN;           // Reset as seen at the boundary

    // Boundary side, faces the host wires
    modport fiu
    (
        input  c0Tx,
        input  c1Tx,
        output c0Rx,
        output c1Rx,
        output c0TxAlmFull,
        output c1TxAlmFull,
        output rstN
    );

    // Read path, read order buffer
    modport rd
    (
        output c0Tx,
        input  c0Rx,
        input  c0TxAlmFull
    );

    // Write path, accelerator request port
    modport wr
    (
        output c1Tx,
        input  c1Rx,
        input  c1TxAlmFull
    );

endinterface

`default_nettype wire

// File: verilog/hostWiresToIf.sv
// Host wire boundary
// Maps host channel wires onto hostChanIf, each direction optionally registered

`timescale 1ns/1ps
`default_nettype none

module hostWiresToIf
    import mpfPkg::*;
#(
    parameter bit registerInputs  = 1,     // Stage responses before the inner blocks
    parameter bit registerOutputs = 0      // Stage requests and almost-full
)
(
    input  logic    clk,
    input  logic    arstN,

    // Host side
    output t_c0Req  hostC0Tx,
    output t_c1Req  hostC1Tx,
    input  t_c0Rsp  hostC0Rx,
    input  t_c1Rsp  hostC1Rx,
    input  logic    hostC0AlmFull,
    input  logic    hostC1AlmFull,

    // Inner side
    hostChanIf.fiu  fiu
);

    assign fiu.rstN = arstN;    // Inner blocks see the same reset

    // ----------------------------------------
    // Requests out, almost-full in
    // ----------------------------------------
    generate
        if (registerOutputs)
        begin : gRegOut
            always_ff @(posedge clk or negedge arstN)
            begin
                if (!arstN)
                begin
                    hostC0Tx        <= '0;     // Valid bits low out of reset
                    hostC1Tx        <= '0;
                    fiu.c0TxAlmFull <= 1'b0;
                    fiu.c1TxAlmFull <= 1'b0;
                end
                else
                begin
                    hostC0Tx        <= fiu.c0Tx;
                    hostC1Tx        <= fiu.c1Tx;
                    fiu.c0TxAlmFull <= hostC0AlmFull;
                    fiu.c1TxAlmFull <= hostC1AlmFull;
                end
            end
        end
        else
        begin : gWireOut
            always_comb
            begin
                hostC0Tx        = fiu.c0Tx;
                hostC1Tx        = fiu.c1Tx;
                fiu.c0TxAlmFull = hostC0AlmFull;
                fiu.c1TxAlmFull = hostC1AlmFull;
            end
        end
    endgenerate

    // ----------------------------------------
    // Responses in
    // ----------------------------------------
    generate
        if (registerInputs)
        begin : gRegIn
            // One stage for timing on the host side
            always_ff @(posedge clk or negedge arstN)
            begin
                if (!arstN)
                begin
                    fiu.c0Rx <= '0;
                    fiu.c1Rx <= '0;
                end
                else
                begin
                    fiu.c0Rx <= hostC0Rx;
                    fiu.c1Rx <= hostC1Rx;
                end
            end
        end
        else
        begin : gWireIn
            always_comb
            begin
                fiu.c0Rx = hostC0Rx;
                fiu.c1Rx = hostC1Rx;
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/mpfPkg.sv
// Host shim types
// Request and response opcodes plus the channel structs

`default_nettype none

`include "mpf_defs.svh"

package mpfPkg;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------

    // Request opcodes on c0/c1 Tx
    typedef enum logic [1:0]
    {
        eReqRdLine = 2'd0,
        eReqWrLine = 2'd1
    } t_reqType;

    // Response opcodes on c0/c1 Rx
    typedef enum logic [1:0]
    {
        eRspRdLine = 2'd0,
        eRspWrAck  = 2'd1
    } t_rspType;

    // ----------------------------------------
    // Channel structs
    // ----------------------------------------

    // c0 Tx, read request
    typedef struct packed
    {
        logic                   valid;
        t_reqType               reqType;
        logic [`MPF_ADDR_W-1:0] addr;
        logic [`MPF_TAG_W-1:0]  tag;      // Returned unchanged in the response
    } t_c0Req;

    // c1 Tx, write request
    typedef struct packed
    {
        logic                   valid;
        t_reqType               reqType;
        logic [`MPF_ADDR_W-1:0] addr;
        logic [`MPF_TAG_W-1:0]  tag;
        logic [`MPF_DATA_W-1:0] data;     // Full line
    } t_c1Req;

    // c0 Rx, read data
    typedef struct packed
    {
        logic                   valid;
        t_rspType               rspType;
        logic [`MPF_TAG_W-1:0]  tag;
        logic [`MPF_DATA_W-1:0] data;
    } t_c0Rsp;

    // c1 Rx, write ack
    typedef struct packed
    {
        logic                   valid;
        t_rspType               rspType;
        logic [`MPF_TAG_W-1:0]  tag;
    } t_c1Rsp;

endpackage

`default_nettype wire

// File: verilog/mpfShim.sv
// Host shim top level
// Boundary block, read order buffer and write port joined by hostChanIf

`timescale 1ns/1ps
`default_nettype none

`include "mpf_defs.svh"

module mpfShim
    import mpfPkg::*;
#(
    parameter bit registerInputs  = 1,
    parameter bit registerOutputs = 0
)
(
    input  logic                    clk,
    input  logic                    arstN,

    // Host side
    output t_c0Req                  hostC0Tx,
    output t_c1Req                  hostC1Tx,
    input  t_c0Rsp                  hostC0Rx,
    input  t_c1Rsp                  hostC1Rx,
    input  logic                    hostC0AlmFull,
    input  logic                    hostC1AlmFull,

    // Accelerator side
    input  logic                    afuRdValid,
    input  logic [`MPF_ADDR_W-1:0]  afuRdAddr,
    input  logic                    afuWrValid,
    input  logic [`MPF_ADDR_W-1:0]  afuWrAddr,
    input  logic [`MPF_DATA_W-1:0]  afuWrData,
    output logic                    afuRdRspValid,
    output logic [`MPF_DATA_W-1:0]  afuRdRspData,
    output logic                    afuWrAckValid,
    output logic                    afuRdAlmFull,
    output logic                    afuWrAlmFull
);

    hostChanIf hostChan ();     // Shared by all three blocks

    hostWiresToIf #(
        .registerInputs  (registerInputs),
        .registerOutputs (registerOutputs)
    ) hostWiresToIf_inst (
        .clk           (clk),
        .arstN         (arstN),
        .hostC0Tx      (hostC0Tx),
        .hostC1Tx      (hostC1Tx),
        .hostC0Rx      (hostC0Rx),
        .hostC1Rx      (hostC1Rx),
        .hostC0AlmFull (hostC0AlmFull),
        .hostC1AlmFull (hostC1AlmFull),
        .fiu           (hostChan.fiu)
    );

    // Reads, reordered
    readOrderBuffer readOrderBuffer_inst (
        .clk       (clk),
        .arstN     (arstN),
        .rdValid   (afuRdValid),
        .rdAddr    (afuRdAddr),
        .rspValid  (afuRdRspValid),
        .rspData   (afuRdRspData),
        .rdAlmFull (afuRdAlmFull),
        .host      (hostChan.rd)
    );

    // Writes and acks
    afuRequestPort afuRequestPort_inst (
        .clk        (clk),
        .arstN      (arstN),
        .wrValid    (afuWrValid),
        .wrAddr     (afuWrAddr),
        .wrData     (afuWrData),
        .wrAckValid (afuWrAckValid),
        .wrAlmFull  (afuWrAlmFull),
        .host       (hostChan.wr)
    );

endmodule

`default_nettype wire

// File: verilog/readOrderBuffer.sv
// Read order buffer
// Tags reads with a slot index, parks out-of-order data, returns it in request order

`timescale 1ns/1ps
`default_nettype none

`include "mpf_defs.svh"

module readOrderBuffer
    import mpfPkg::*;
(
    input  logic                    clk,
    input  logic                    arstN,

    // Accelerator side
    input  logic                    rdValid,
    input  logic [`MPF_ADDR_W-1:0]  rdAddr,
    output logic                    rspValid,
    output logic [`MPF_DATA_W-1:0]  rspData,
    output logic                    rdAlmFull,

    // Host side
    hostChanIf.rd                   host
);

    localparam int idxW = `MPF_ROB_IDX_W;
    localparam int padW = `MPF_TAG_W - `MPF_ROB_IDX_W;     // Unused upper tag bits

    localparam logic [idxW:0] robDepth  = (idxW+1)'(`MPF_ROB_DEPTH);
    localparam logic [idxW:0] almThresh = (idxW+1)'(2);    // Keep one slot in hand

    // ----------------------------------------
    // Slot storage
    // ----------------------------------------
    logic [`MPF_DATA_W-1:0] slotData [`MPF_ROB_DEPTH];     // Payload, no reset
    logic [`MPF_ROB_DEPTH-1:0] filled;                     // Data present per slot

    logic [idxW-1:0] allocPtr;     // Next tag to hand out
    logic [idxW-1:0] oldestPtr;    // Next slot to return
    logic [idxW:0]   freeCount;    // Unallocated slots

    logic            rdAccept;
    logic            rspWrite;
    logic [idxW-1:0] rspSlot;
    logic            oldestReady;

    assign rdAccept    = rdValid && (freeCount != '0);    // Full buffer drops the read
    assign rspWrite    = host.c0Rx.valid && (host.c0Rx.rspType == eRspRdLine);
    assign rspSlot     = host.c0Rx.tag[idxW-1:0];         // Tag low bits name the slot
    assign oldestReady = filled[oldestPtr];               // Oldest ready, hand it back

    // ----------------------------------------
    // Request toward host
    // ----------------------------------------
    always_comb
    begin
        host.c0Tx.valid   = rdAccept;
        host.c0Tx.reqType = eReqRdLine;
        host.c0Tx.addr    = rdAddr;
        host.c0Tx.tag     = {{padW{1'b0}}, allocPtr};
    end

    // Response data into its slot
    always_ff @(posedge clk)
    begin
        if (rspWrite)
        begin
            slotData[rspSlot] <= host.c0Rx.data;
        end
    end

    // Filled bits, set on arrival and cleared on release
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            filled <= '0;
        end
        else
        begin
            if (oldestReady)
            begin
                filled[oldestPtr] <= 1'b0;
            end
            if (rspWrite)
            begin
                filled[rspSlot] <= 1'b1;   // Never the slot being released
            end
        end
    end

    // ----------------------------------------
    // Pointers and free count
    // ----------------------------------------
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            allocPtr  <= '0;
            oldestPtr <= '0;
            freeCount <= robDepth;
        end
        else
        begin
            if (rdAccept)
            begin
                allocPtr <= allocPtr + 1'b1;   // Wraps with the slot count
            end
            if (oldestReady)
            begin
                oldestPtr <= oldestPtr + 1'b1;
            end
            case ({rdAccept, oldestReady})
                2'b10:   freeCount <= freeCount - 1'b1;
                2'b01:   freeCount <= freeCount + 1'b1;
                default: freeCount <= freeCount;   // Both or neither
            endcase
        end
    end

    // Return path, combinational from the oldest slot
    assign rspValid  = oldestReady;
    assign rspData   = slotData[oldestPtr];
    assign rdAlmFull = host.c0TxAlmFull || (freeCount < almThresh);

endmodule

`default_nettype wire
